//--- Makefile
# Verilator build and run of the retire pointer testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= retire_tb
FILELIST  ?= retire_ptrs.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# a failing check ends in $$fatal, so the exit status carries the result
run: $(SIM)
	$(SIM)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- hw/commit_select.sv
// ============================================================
// in-order retire decision over the head slots
// a slot retires when it and every older slot are valid and
// done, and the number retiring becomes the commit amount
// ============================================================

`timescale 1ns/10ps

module commit_select (
	rob_if.select                        cs,
	output logic [rob_geom_pkg::RSLOTS-1:0] commit_valid
);
	import rob_geom_pkg::*;

	// stays high while every slot seen so far is ready to retire
	logic run;

	// the scan stops at the first slot that is empty or still waiting,
	// so younger results that came back early wait behind it
	// slot 1 can therefore only retire together with slot 0
	always_comb begin
		run     = 1'b1;
		cs.ramt = '0;
		for (int i = 0; i < RSLOTS; i++) begin
			run             = run & cs.slot_valid[i] & cs.slot_done[i];
			commit_valid[i] = run;
			cs.ramt         = cs.ramt + amt_t'(run);
		end
	end

	// commit_valid is a prefix mask, oldest slot in bit 0, and ramt
	// is its population count
	// the destination register of each slot is taken from the slot
	// view at the top level next to commit_valid

endmodule

//--- hw/head_ptrs.sv
// ============================================================
// rotating head index sets for the fetch queue and for the
// reorder buffer commit slots
// every element moves forward by the amount consumed in the
// cycle and wraps at the depth of its own queue
// ============================================================

`timescale 1ns/10ps

module head_ptrs (
	input  logic                clk,
	input  logic                rst,
	input  rob_geom_pkg::amt_t  q_amt,
	output rob_geom_pkg::qidx_t q_heads [rob_geom_pkg::QENTRIES],
	rob_if.heads                hp
);
	import rob_geom_pkg::*;

	// ========================================================
	// fetch queue heads
	// ========================================================

	// each element starts at its own position, so the set always reads
	// as consecutive indices starting at the oldest queue entry
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < QENTRIES; i++) begin
				q_heads[i] <= qidx_t'(i);
			end
		end else begin
			// the index is three bits wide, so the sum wraps modulo 8
			for (int i = 0; i < QENTRIES; i++) begin
				q_heads[i] <= q_heads[i] + qidx_t'(q_amt);
			end
		end
	end

	// ========================================================
	// reorder buffer commit slot heads
	// ========================================================

	// slot 0 is the oldest entry and slot 1 the one after it
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < RSLOTS; i++) begin
				hp.slot_idx[i] <= ridx_t'(i);
			end
		end else begin
			// four bit index wraps modulo RENTRIES
			for (int i = 0; i < RSLOTS; i++) begin
				hp.slot_idx[i] <= hp.slot_idx[i] + ridx_t'(hp.ramt);
			end
		end
	end

endmodule

//--- hw/retire_top.sv
// ============================================================
// top level of the retire pointer subsystem
// dispatch allocates entries at the tail, completions mark
// them done, and up to two retire in order at the head each
// cycle; the fetch queue heads advance by q_amt every cycle
// ============================================================

`timescale 1ns/10ps

module retire_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 dispatch,
	input  rob_entry_pkg::dreg_t dispatch_dreg,
	output logic                 dispatch_ready,
	output rob_geom_pkg::ridx_t  dispatch_tag,
	input  logic                 complete,
	input  rob_geom_pkg::ridx_t  complete_tag,
	input  rob_geom_pkg::amt_t   q_amt,
	output logic [rob_geom_pkg::QENTRIES*rob_geom_pkg::QIDX_W-1:0] q_heads,
	output logic [rob_geom_pkg::RSLOTS-1:0] commit_valid,
	output logic [rob_geom_pkg::RSLOTS*rob_entry_pkg::DREG_W-1:0] commit_dreg,
	output rob_geom_pkg::cnt_t   rob_count
);
	import rob_geom_pkg::*;
	import rob_entry_pkg::*;

	rob_if rif ();

	// dispatch strobe that the buffer actually takes
	logic  accept;
	logic  full;
	qidx_t q_heads_a [QENTRIES];

	// a strobe while the buffer is full is dropped here
	assign dispatch_ready = ~full;
	assign accept         = dispatch & dispatch_ready;

	// ========================================================
	// blocks
	// ========================================================

	head_ptrs u_heads (
		.clk     (clk),
		.rst     (rst),
		.q_amt   (q_amt),
		.q_heads (q_heads_a),
		.hp      (rif.heads)
	);

	rob_tail u_tail (
		.clk    (clk),
		.rst    (rst),
		.accept (accept),
		.ramt   (rif.ramt),
		.tail   (dispatch_tag),
		.count  (rob_count),
		.full   (full)
	);

	rob_store u_store (
		.clk          (clk),
		.rst          (rst),
		.wr           (accept),
		.wr_idx       (dispatch_tag),
		.wr_dreg      (dispatch_dreg),
		.complete     (complete),
		.complete_tag (complete_tag),
		.rs           (rif.store)
	);

	commit_select u_select (
		.cs           (rif.select),
		.commit_valid (commit_valid)
	);

	// ========================================================
	// flattened outputs
	// ========================================================

	// element 0 sits in the lowest bits of each vector
	for (genvar i = 0; i < QENTRIES; i++) begin : g_qh
		assign q_heads[i*QIDX_W +: QIDX_W] = q_heads_a[i];
	end

	for (genvar i = 0; i < RSLOTS; i++) begin : g_cd
		assign commit_dreg[i*DREG_W +: DREG_W] = rif.slot_dreg[i];
	end

endmodule

//--- hw/rob_entry_pkg.sv
// ============================================================
// field types carried by one reorder buffer entry
// only the destination register number travels with an
// instruction in this subsystem
// ============================================================

package rob_entry_pkg;

	// architectural register file holds 32 registers
	localparam int DREG_W = 5;

	// destination architectural register number
	typedef logic [DREG_W-1:0] dreg_t;

	// a retiring entry reports this value on its commit slot, so the
	// width here fixes the flattened commit_dreg width at the top level

endpackage

//--- hw/rob_geom_pkg.sv
// ============================================================
// sizes of the fetch queue and the reorder buffer, together
// with the index, amount and count types built on them
// imported by every block that handles head or tail indices
// ============================================================

package rob_geom_pkg;

	// fetch queue depth and its index width
	localparam int QENTRIES = 8;
	localparam int QIDX_W   = 3;

	// reorder buffer depth and its index width
	localparam int RENTRIES = 16;
	localparam int RIDX_W   = 4;

	// head slots examined for retirement each cycle
	localparam int RSLOTS = 2;

	// the advance amount is four bits wide, as on the fetch side
	localparam int AMT_W = 4;

	// the occupancy count must reach RENTRIES itself
	localparam int CNT_W = 5;

	typedef logic [QIDX_W-1:0] qidx_t;
	typedef logic [RIDX_W-1:0] ridx_t;
	typedef logic [AMT_W-1:0]  amt_t;
	typedef logic [CNT_W-1:0]  cnt_t;

endpackage

//--- hw/rob_if.sv
// ============================================================
// head slot view of the reorder buffer and the commit amount
// head_ptrs supplies the slot indices, rob_store the entry
// status behind them, commit_select the number that retires
// ============================================================

`timescale 1ns/10ps

interface rob_if;
	import rob_geom_pkg::*;
	import rob_entry_pkg::*;

	// buffer index of each head slot, oldest first
	ridx_t slot_idx [RSLOTS];

	// status of the entry behind each head slot
	logic [RSLOTS-1:0] slot_valid;
	logic [RSLOTS-1:0] slot_done;
	dreg_t             slot_dreg [RSLOTS];

	// number of head slots retiring in this cycle
	amt_t ramt;

	// the heads advance by the amount that retired
	modport heads (output slot_idx, input ramt);

	// the store reads entries at the heads and clears the retired ones
	modport store (input slot_idx, input ramt,
		output slot_valid, output slot_done, output slot_dreg);

	// the retire decision looks only at the slot view
	modport select (input slot_valid, input slot_done, input slot_dreg,
		output ramt);

endinterface

//--- hw/rob_store.sv
// ============================================================
// entry storage of the reorder buffer
// holds valid, done and destination register for each entry,
// writes new entries, marks completions, clears retired heads
// and presents the head slots through the interface
// ============================================================

`timescale 1ns/10ps

module rob_store (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 wr,
	input  rob_geom_pkg::ridx_t  wr_idx,
	input  rob_entry_pkg::dreg_t wr_dreg,
	input  logic                 complete,
	input  rob_geom_pkg::ridx_t  complete_tag,
	rob_if.store                 rs
);
	import rob_geom_pkg::*;
	import rob_entry_pkg::*;

	// one status bit per entry for allocation and for completion
	logic [RENTRIES-1:0] valid;
	logic [RENTRIES-1:0] done;

	// destination register of each entry
	dreg_t dreg [RENTRIES];

	// ========================================================
	// entry status
	// ========================================================

	// a write only ever targets the tail, which holds no valid entry
	// unless the buffer is full, and a full buffer accepts no write
	// retire clears only valid entries at the head, so the two updates
	// never meet on the same entry
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
			done  <= '0;
		end else begin
			// a new entry starts out waiting for its result
			if (wr) begin
				valid[wr_idx] <= 1'b1;
				done[wr_idx]  <= 1'b0;
			end

			// results for entries that were never dispatched are dropped
			if (complete && valid[complete_tag]) begin
				done[complete_tag] <= 1'b1;
			end

			// the first ramt head slots leave the buffer at this edge
			for (int i = 0; i < RSLOTS; i++) begin
				if (amt_t'(i) < rs.ramt) begin
					valid[rs.slot_idx[i]] <= 1'b0;
				end
			end
		end
	end

	// ========================================================
	// destination register payload
	// ========================================================

	// the payload is only read while valid is set, so it is simply
	// overwritten on each dispatch
	always_ff @(posedge clk) begin
		if (wr) begin
			dreg[wr_idx] <= wr_dreg;
		end
	end

	// ========================================================
	// head slot view
	// ========================================================

	// read straight from the registered entries at the head indices,
	// so the retire decision sees the state as of the last edge
	always_comb begin
		for (int i = 0; i < RSLOTS; i++) begin
			rs.slot_valid[i] = valid[rs.slot_idx[i]];
			rs.slot_done[i]  = done[rs.slot_idx[i]];
			rs.slot_dreg[i]  = dreg[rs.slot_idx[i]];
		end
	end

endmodule

//--- hw/rob_tail.sv
// ============================================================
// allocation side of the reorder buffer
// keeps the dispatch tail index and the number of occupied
// entries, and reports full when all entries are in use
// ============================================================

`timescale 1ns/10ps

module rob_tail (
	input  logic               clk,
	input  logic               rst,
	input  logic               accept,
	input  rob_geom_pkg::amt_t ramt,
	output rob_geom_pkg::ridx_t tail,
	output rob_geom_pkg::cnt_t count,
	output logic               full
);
	import rob_geom_pkg::*;

	// the tail names the entry that the next accepted dispatch fills
	// and moves on by one for each accepted dispatch
	always_ff @(posedge clk) begin
		if (rst) begin
			tail <= '0;
		end else if (accept) begin
			tail <= tail + ridx_t'(1);
		end
	end

	// occupancy rises with a dispatch and falls with the entries that
	// retire in the same cycle
	// both happen in one update, so a full buffer that retires and
	// drops a dispatch in the same cycle still frees its space
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			count <= count + cnt_t'(accept) - cnt_t'(ramt);
		end
	end

	// the tail and the oldest head coincide both when empty and when
	// full, so the count tells the two apart
	assign full = (count == cnt_t'(RENTRIES));

endmodule

//--- retire_ptrs.f
hw/rob_geom_pkg.sv
hw/rob_entry_pkg.sv
hw/rob_if.sv
hw/head_ptrs.sv
hw/rob_tail.sv
hw/rob_store.sv
hw/commit_select.sv
hw/retire_top.sv
verif/retire_sva.sv
verif/retire_tb.sv

//--- verif/retire_sva.sv
// ============================================================
// concurrent assertions on occupancy and commit rules,
// bound into every instance of the retire top level
// ============================================================

`timescale 1ns/10ps

module retire_sva (
	input logic                               clk,
	input logic                               rst,
	input rob_geom_pkg::cnt_t                 rob_count,
	input logic                               dispatch_ready,
	input logic [rob_geom_pkg::RSLOTS-1:0]    commit_valid
);
	import rob_geom_pkg::*;

	// the buffer never holds more entries than it has
	a_count_max: assert property (@(posedge clk) disable iff (rst)
		rob_count <= cnt_t'(RENTRIES))
		else $error("rob_count went above the buffer depth");

	// back-pressure starts only as a dispatch takes the last free entry
	a_ready_fall: assert property (@(posedge clk) disable iff (rst)
		$fell(dispatch_ready) |-> ($past(rob_count) == cnt_t'(RENTRIES - 1)))
		else $error("dispatch_ready fell without the last free entry being taken");

	// the second slot never retires ahead of the oldest one
	a_in_order: assert property (@(posedge clk) disable iff (rst)
		$rose(commit_valid[1]) |-> commit_valid[0])
		else $error("commit slot 1 retired without slot 0");

endmodule

bind retire_top retire_sva u_sva (
	.clk            (clk),
	.rst            (rst),
	.rob_count      (rob_count),
	.dispatch_ready (dispatch_ready),
	.commit_valid   (commit_valid)
);

//--- verif/retire_tb.sv
// ============================================================
// table driven testbench for the retire pointer subsystem
// directed rows are followed by seeded random rows, and a
// reference model predicts every output before each edge
// ============================================================

`timescale 1ns/10ps

module retire_tb;
	import rob_geom_pkg::*;
	import rob_entry_pkg::*;

	localparam int PERIOD       = 20;
	localparam int RESET_CYCLES = 10;
	localparam int RAND_ROWS    = 40;

	// one cycle of stimulus
	typedef struct packed {
		logic  disp;
		dreg_t dreg;
		logic  comp;
		ridx_t ctag;
		amt_t  qamt;
	} row_t;

	logic  clk;
	logic  rst;
	logic  dispatch;
	dreg_t dispatch_dreg;
	logic  dispatch_ready;
	ridx_t dispatch_tag;
	logic  complete;
	ridx_t complete_tag;
	amt_t  q_amt;
	logic [QENTRIES*QIDX_W-1:0] q_heads;
	logic [RSLOTS-1:0]          commit_valid;
	logic [RSLOTS*DREG_W-1:0]   commit_dreg;
	cnt_t  rob_count;

	row_t   rows [$];
	int     n_directed;
	logic   table_built;
	integer seed;

	// reference model: entries in program order from the oldest one
	dreg_t m_dreg [$];
	logic  m_done [$];
	int    qbase;
	int    rhead;
	int    rtail;

	retire_top UUT (
		.clk            (clk),
		.rst            (rst),
		.dispatch       (dispatch),
		.dispatch_dreg  (dispatch_dreg),
		.dispatch_ready (dispatch_ready),
		.dispatch_tag   (dispatch_tag),
		.complete       (complete),
		.complete_tag   (complete_tag),
		.q_amt          (q_amt),
		.q_heads        (q_heads),
		.commit_valid   (commit_valid),
		.commit_dreg    (commit_dreg),
		.rob_count      (rob_count)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk;
	end

	// ========================================================
	// helpers
	// ========================================================

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic add_row(input logic d, input int dreg, input logic c, input int tag,
		input int qamt);
		row_t r;
		r.disp = d;
		r.dreg = dreg_t'(dreg);
		r.comp = c;
		r.ctag = ridx_t'(tag);
		r.qamt = amt_t'(qamt);
		rows.push_back(r);
	endtask

	// how many of the oldest entries retire in front of the next edge
	function automatic int retire_count();
		int n;
		n = 0;
		for (int i = 0; i < RSLOTS; i++) begin
			if (n == i && i < m_done.size() && m_done[i]) n = i + 1;
		end
		return n;
	endfunction

	// maps a random hint onto an entry that is dispatched but not done
	function automatic ridx_t pick_outstanding(input ridx_t hint);
		int open_cnt;
		int want;
		open_cnt = 0;
		for (int k = 0; k < m_done.size(); k++) begin
			if (!m_done[k]) open_cnt++;
		end
		if (open_cnt == 0) return hint;
		want = int'(hint) % open_cnt;
		for (int k = 0; k < m_done.size(); k++) begin
			if (!m_done[k]) begin
				if (want == 0) return ridx_t'((rhead + k) % RENTRIES);
				want--;
			end
		end
		return hint;
	endfunction

	task automatic check_outputs();
		logic [QENTRIES*QIDX_W-1:0] eq;
		logic [RSLOTS-1:0]          ecv;
		logic [RSLOTS*DREG_W-1:0]   edr;
		logic [RSLOTS*DREG_W-1:0]   mask;
		int n;
		n    = retire_count();
		edr  = '0;
		mask = '0;
		for (int i = 0; i < QENTRIES; i++) begin
			eq[i*QIDX_W +: QIDX_W] = qidx_t'((qbase + i) % QENTRIES);
		end
		// commit_dreg only carries meaning on the slots that retire
		for (int i = 0; i < RSLOTS; i++) begin
			ecv[i] = (i < n);
			if (i < n) begin
				edr[i*DREG_W +: DREG_W]  = m_dreg[i];
				mask[i*DREG_W +: DREG_W] = '1;
			end
		end
		check("q_heads", 32'(q_heads), 32'(eq));
		check("rob_count", 32'(rob_count), 32'(cnt_t'(m_dreg.size())));
		check("dispatch_ready", 32'(dispatch_ready), 32'(m_dreg.size() < RENTRIES));
		check("dispatch_tag", 32'(dispatch_tag), 32'(ridx_t'(rtail)));
		check("commit_valid", 32'(commit_valid), 32'(ecv));
		check("commit_dreg", 32'(commit_dreg & mask), 32'(edr));
	endtask

	// advances the model across one rising edge with the row applied
	task automatic model_step(input row_t r);
		int n;
		n = retire_count();
		// completions only see entries that were valid before the edge
		if (r.comp) begin
			for (int k = 0; k < m_done.size(); k++) begin
				if (ridx_t'((rhead + k) % RENTRIES) == r.ctag) m_done[k] = 1'b1;
			end
		end
		if (r.disp && m_dreg.size() < RENTRIES) begin
			m_dreg.push_back(r.dreg);
			m_done.push_back(1'b0);
			rtail = (rtail + 1) % RENTRIES;
		end
		for (int i = 0; i < n; i++) begin
			void'(m_dreg.pop_front());
			void'(m_done.pop_front());
		end
		rhead = (rhead + n) % RENTRIES;
		qbase = (qbase + int'(r.qamt)) % QENTRIES;
	endtask

	// ========================================================
	// stimulus table
	// ========================================================

	task automatic build_table();
		row_t r;
		// reset state, then fetch head amounts including wrap and 15
		add_row(0, 0, 0, 0, 0);
		add_row(0, 0, 0, 0, 3);
		add_row(0, 0, 0, 0, 5);
		add_row(0, 0, 0, 0, 7);
		add_row(0, 0, 0, 0, 15);
		// tag 9 holds nothing yet, so this completion is ignored
		add_row(0, 0, 1, 9, 1);
		// tag 0 is only being filled by this dispatch, so its completion is ignored
		add_row(1, 'h11, 1, 0, 0);
		add_row(1, 'h12, 0, 0, 0);
		add_row(1, 'h13, 0, 0, 0);
		// younger ones finish first and have to wait for tag 0
		add_row(0, 0, 1, 2, 0);
		add_row(0, 0, 1, 1, 0);
		add_row(0, 0, 1, 0, 0);
		add_row(0, 0, 0, 0, 0);
		add_row(1, 'h14, 0, 0, 2);
		// fill up to sixteen, then a dropped dispatch
		for (int i = 0; i < 15; i++) begin
			add_row(1, i + 1, 0, 0, 0);
		end
		add_row(1, 'h1f, 0, 0, 0);
		add_row(1, 'h1e, 1, 3, 0);
		add_row(1, 'h1d, 0, 0, 0);
		add_row(1, 'h1c, 0, 0, 0);
		add_row(0, 0, 0, 0, 0);
		n_directed = rows.size();
		for (int i = 0; i < RAND_ROWS; i++) begin
			r.disp = 1'($random(seed));
			r.dreg = dreg_t'($random(seed));
			r.comp = (($random(seed) & 3) != 0);
			r.ctag = ridx_t'($random(seed));
			r.qamt = amt_t'($random(seed));
			rows.push_back(r);
		end
	endtask

	// ========================================================
	// main sequence
	// ========================================================

	initial begin
		row_t r;
		rst           = 1'b1;
		dispatch      = 1'b0;
		dispatch_dreg = '0;
		complete      = 1'b0;
		complete_tag  = '0;
		q_amt         = '0;
		table_built   = 1'b0;
		seed          = 32'h3a4b;
		qbase         = 0;
		rhead         = 0;
		rtail         = 0;
		build_table();
		table_built = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int k = 0; k < rows.size(); k++) begin
			r = rows[k];
			if (k >= n_directed && r.comp) r.ctag = pick_outstanding(r.ctag);
			@(negedge clk);
			dispatch      = r.disp;
			dispatch_dreg = r.dreg;
			complete      = r.comp;
			complete_tag  = r.ctag;
			q_amt         = r.qamt;
			#1;
			check_outputs();
			model_step(r);
		end
		@(negedge clk);
		$display("Simulation finished: PASS");
		$finish;
	end

	// the run takes one cycle per row after reset, doubled for margin
	initial begin
		wait (table_built);
		#((rows.size() + RESET_CYCLES + 4) * PERIOD * 2);
		$display("timeout: the stimulus table did not finish in the expected time");
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule
